// File: dv/xl320_ctrl_tb.sv
`timescale 1ns/1ps

module xl320_ctrl_tb;

	import xl320_pkg::*;

	localparam int CLKS_PER_BIT = 4;
	localparam int CLK_NS = 4;
	localparam int BYTE_CYCLES = 10 * CLKS_PER_BIT;
	localparam int NUM_RANDOM = 40;
	localparam int NUM_FRAMES = NUM_RANDOM + 3;
	// worst case of 14 bytes per frame plus a margin for register traffic and idle gaps
	localparam int TIMEOUT_NS = NUM_FRAMES * 14 * 10 * CLKS_PER_BIT * CLK_NS + 25000;
	localparam int NUM_WIDE = 11;
	localparam logic [15:0] WIDE_LIST [NUM_WIDE] = '{
		16'd0, 16'd6, 16'd8, 16'd15, 16'd30, 16'd32, 16'd35, 16'd37, 16'd39, 16'd41, 16'd51
	};
	localparam logic [7:0] INST_LIST [11] = '{
		8'h01, 8'h02, 8'h03, 8'h04, 8'h05, 8'h06, 8'h08, 8'h82, 8'h83, 8'h92, 8'h93
	};

	logic        clock;
	logic        reset;
	logic [15:0] address;
	logic        write;
	logic [31:0] writedata;
	logic        read;
	logic [31:0] readdata;
	logic        waitrequest;
	logic        serial;
	logic        busy;

	logic [31:0] lcg_state;
	logic [7:0]  rx_q[$];
	logic [7:0]  exp_q[$];
	int          checks;
	int          value_errors;
	int          other_errors;

	xl320_ctrl #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) UUT (
		.i_clock       (clock),
		.i_reset       (reset),
		.i_address     (address),
		.i_write       (write),
		.i_writedata   (writedata),
		.i_read        (read),
		.o_readdata    (readdata),
		.o_waitrequest (waitrequest),
		.o_serial      (serial),
		.o_busy        (busy)
	);

	always #(CLK_NS / 2) clock = ~clock;

	function logic [15:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16];
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			value_errors++;
			$display("ERR %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	function automatic logic wide_value(input logic [15:0] addr);
		logic wide;
		wide = 1'b0;
		foreach (WIDE_LIST[k]) begin
			wide = wide | (addr == WIDE_LIST[k]);
		end
		return wide;
	endfunction

	// bit serial form with one input bit per shift
	function automatic logic [15:0] crc_of_expected();
		logic [15:0] crc;
		logic        fb;
		crc = 16'h0000;
		foreach (exp_q[i]) begin
			for (int b = 7; b >= 0; b--) begin
				fb  = crc[15] ^ exp_q[i][b];
				crc = {crc[14:0], 1'b0};
				if (fb) begin
					crc = crc ^ 16'h8005;
				end
			end
		end
		return crc;
	endfunction

	task automatic write_reg(input logic [7:0] sel, input logic [31:0] data);
		@(negedge clock);
		address   = {sel, 8'h00};
		writedata = data;
		write     = 1'b1;
		@(negedge clock);
		write = 1'b0;
	endtask

	task automatic check_reg(input logic [7:0] sel, input logic [31:0] exp);
		@(negedge clock);
		address = {sel, 8'h00};
		read    = 1'b1;
		#1;
		check_value("o_waitrequest", waitrequest, 32'd1);
		@(negedge clock);
		check_value("o_waitrequest", waitrequest, 32'd0);
		check_value($sformatf("o_readdata reg %0d", sel), readdata, exp);
		read = 1'b0;
	endtask

	task automatic load_command(input logic [7:0] id, input logic [7:0] inst,
			input logic [15:0] addr, input logic [15:0] value);
		logic [15:0] crc;
		write_reg(REG_MOTOR_ID, {24'h0, id});
		write_reg(REG_INSTRUCTION, {24'h0, inst});
		write_reg(REG_MOTOR_ADDRESS, {16'h0, addr});
		write_reg(REG_VALUE, {16'h0, value});
		exp_q.delete();
		exp_q.push_back(8'hFF);
		exp_q.push_back(8'hFF);
		exp_q.push_back(8'hFD);
		exp_q.push_back(8'h00);
		exp_q.push_back(id);
		exp_q.push_back(wide_value(addr) ? 8'd2 : 8'd1);
		exp_q.push_back(8'h00);
		exp_q.push_back(inst);
		exp_q.push_back(addr[7:0]);
		exp_q.push_back(addr[15:8]);
		exp_q.push_back(value[7:0]);
		if (wide_value(addr)) begin
			exp_q.push_back(value[15:8]);
		end
		crc = crc_of_expected();
		exp_q.push_back(crc[7:0]);
		exp_q.push_back(crc[15:8]);
		rx_q.delete();
	endtask

	task automatic wait_for_bytes(input int count);
		int cycles;
		cycles = 0;
		while (rx_q.size() < count && cycles < (count + 2) * BYTE_CYCLES) begin
			@(negedge clock);
			cycles++;
		end
		if (rx_q.size() < count) begin
			other_errors++;
			$display("timed out waiting for %0d serial bytes, got %0d", count, rx_q.size());
		end
	endtask

	task automatic compare_frame();
		int cycles;
		wait_for_bytes(exp_q.size());
		foreach (exp_q[i]) begin
			if (i < rx_q.size()) begin
				check_value($sformatf("o_serial byte %0d", i), rx_q[i], exp_q[i]);
			end
		end
		cycles = 0;
		while (busy && cycles < 4 * BYTE_CYCLES) begin
			@(negedge clock);
			cycles++;
		end
		check_value("o_busy", busy, 32'd0);
		check_value("serial byte count", rx_q.size(), exp_q.size());
	endtask

	// samples each bit near its middle on the falling clock edge
	initial begin : serial_decoder
		logic [7:0] data;
		@(negedge reset);
		forever begin
			@(negedge serial);
			repeat (CLKS_PER_BIT / 2) @(negedge clock);
			if (serial !== 1'b0) begin
				other_errors++;
				$display("start bit on o_serial did not hold low at %0t", $time);
			end else begin
				for (int b = 0; b < 8; b++) begin
					repeat (CLKS_PER_BIT) @(negedge clock);
					data[b] = serial;
				end
				repeat (CLKS_PER_BIT) @(negedge clock);
				if (serial !== 1'b1) begin
					other_errors++;
					$display("missing stop bit after serial byte %h at %0t", data, $time);
				end
				rx_q.push_back(data);
			end
		end
	end

	initial begin : watchdog
		#(TIMEOUT_NS);
		$display("watchdog expired after %0d ns, the run did not finish", TIMEOUT_NS);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		logic [15:0] rnd;
		logic [15:0] addr;
		logic [15:0] value;
		logic [7:0]  id;
		logic [7:0]  inst;
		lcg_state    = 32'h9e77;
		checks       = 0;
		value_errors = 0;
		other_errors = 0;
		clock        = 1'b0;
		reset        = 1'b1;
		address      = '0;
		write        = 1'b0;
		writedata    = '0;
		read         = 1'b0;
		repeat (4) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		check_value("o_serial", serial, 32'd1);
		check_value("o_busy", busy, 32'd0);
		check_value("o_waitrequest", waitrequest, 32'd0);

		// model crc against the catalog check value of the ascii digits 1 to 9
		exp_q.delete();
		for (int i = 0; i < 9; i++) begin
			exp_q.push_back(8'h31 + i);
		end
		check_value("model crc", crc_of_expected(), 32'h0000_FEE8);

		// register read-back where wider writes return only the held low bits
		write_reg(REG_MOTOR_ID, 32'hFFFF_FFA5);
		write_reg(REG_VALUE, 32'hABCD_1234);
		write_reg(REG_MOTOR_ADDRESS, 32'h5555_0123);
		write_reg(REG_INSTRUCTION, 32'h0000_0082);
		check_reg(REG_MOTOR_ID, 32'h0000_00A5);
		check_reg(REG_VALUE, 32'h0000_1234);
		check_reg(REG_MOTOR_ADDRESS, 32'h0000_0123);
		check_reg(REG_INSTRUCTION, 32'h0000_0082);
		check_reg(8'h10, 32'hDEAD_BEEF);
		check_reg(REG_STATUS, 32'd0);

		// one byte value, then a two byte value
		load_command(8'h01, 8'h03, 16'd25, 16'h125A);
		write_reg(REG_SEND, 32'd1);
		compare_frame();
		check_reg(REG_SEND, 32'd1);
		load_command(8'h07, 8'h03, 16'd30, 16'h03FF);
		write_reg(REG_SEND, 32'd1);
		compare_frame();

		// busy status and a send that lands mid frame
		load_command(8'h02, 8'h04, 16'd24, 16'h0001);
		write_reg(REG_SEND, 32'd1);
		wait_for_bytes(2);
		check_value("o_busy", busy, 32'd1);
		check_reg(REG_STATUS, 32'd1);
		write_reg(REG_SEND, 32'd1);
		compare_frame();
		check_reg(REG_STATUS, 32'd0);
		repeat (3 * BYTE_CYCLES) @(negedge clock);
		check_value("serial byte count", rx_q.size(), exp_q.size());

		for (int n = 0; n < NUM_RANDOM; n++) begin
			rnd = next_random();
			if (rnd[0]) begin
				addr = WIDE_LIST[next_random() % NUM_WIDE];
			end else begin
				addr = next_random() % 16'd64;
			end
			rnd   = next_random();
			id    = rnd[7:0];
			inst  = INST_LIST[next_random() % 11];
			value = next_random();
			load_command(id, inst, addr, value);
			write_reg(REG_SEND, 32'd1);
			compare_frame();
		end

		$display("checks %0d, value errors %0d, other errors %0d",
			checks, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: src/xl320_cmd_regs.sv
`timescale 1ns/1ps

module xl320_cmd_regs (
	input  logic                i_clock,
	input  logic                i_reset,
	input  logic [15:0]         i_address,
	input  logic                i_write,
	input  logic [31:0]         i_writedata,
	input  logic                i_read,
	input  logic                i_busy,
	output logic [31:0]         o_readdata,
	output logic                o_waitrequest,
	output xl320_pkg::cmd_t     o_cmd,
	output logic                o_send
);

	import xl320_pkg::*;

	reg_sel_e    sel;
	cmd_t        cmd_q;
	logic        send_flag;
	logic        rd_done;
	logic [31:0] rd_mux;
	logic [31:0] readdata_q;

	assign sel = reg_sel_e'(i_address[15:8]);

	// host writes land in one cycle, send fires a pulse on the next
	always_ff @(posedge i_clock or posedge i_reset) begin
		if (i_reset) begin
			cmd_q     <= '0;
			send_flag <= 1'b0;
			o_send    <= 1'b0;
		end else begin
			o_send <= 1'b0;
			if (i_write) begin
				case (sel)
					REG_MOTOR_ID:      cmd_q.id <= i_writedata[7:0];
					REG_VALUE:         cmd_q.value <= i_writedata[15:0];
					REG_MOTOR_ADDRESS: cmd_q.address <= i_writedata[15:0];
					REG_INSTRUCTION:   cmd_q.instruction <= dxl_inst_e'(i_writedata[7:0]);
					REG_SEND: begin
						send_flag <= |i_writedata;
						o_send    <= |i_writedata;
					end
					default: begin
					end
				endcase
			end
		end
	end

	always_comb begin
		case (sel)
			REG_MOTOR_ID:      rd_mux = {24'h0, cmd_q.id};
			REG_VALUE:         rd_mux = {16'h0, cmd_q.value};
			REG_MOTOR_ADDRESS: rd_mux = {16'h0, cmd_q.address};
			REG_INSTRUCTION:   rd_mux = {24'h0, cmd_q.instruction};
			REG_SEND:          rd_mux = {31'h0, send_flag};
			REG_STATUS:        rd_mux = {31'h0, i_busy};
			default:           rd_mux = BAD_READ;
		endcase
	end

	// first read cycle stalls and captures, second one returns the data
	always_ff @(posedge i_clock or posedge i_reset) begin
		if (i_reset) begin
			rd_done <= 1'b0;
		end else begin
			rd_done <= i_read && !rd_done;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_read && !rd_done) begin
			readdata_q <= rd_mux;
		end
	end

	assign o_readdata    = readdata_q;
	assign o_waitrequest = i_read && !rd_done;
	assign o_cmd         = cmd_q;

	// a stall only comes with a read and never lasts past one cycle
	property p_wait_one_cycle;
		@(posedge i_clock) disable iff (i_reset)
		o_waitrequest |-> i_read ##1 (!i_read || !o_waitrequest);
	endproperty
	a_wait_one_cycle: assert property (p_wait_one_cycle);

endmodule

// File: src/xl320_crc16.sv
`timescale 1ns/1ps

module xl320_crc16 (
	input  logic        i_clock,
	input  logic        i_reset,
	input  logic        i_clear,
	input  logic        i_byte_valid,
	input  logic [7:0]  i_byte,
	output logic [15:0] o_crc
);

	import xl320_pkg::*;

	logic [15:0] crc_q;

	// msb first, no reflection, eight shifts per byte
	function automatic logic [15:0] crc_step(input logic [15:0] crc, input logic [7:0] data);
		logic [15:0] c;
		c = crc ^ {data, 8'h00};
		for (int i = 0; i < 8; i++) begin
			if (c[15]) begin
				c = {c[14:0], 1'b0} ^ CRC_POLY;
			end else begin
				c = {c[14:0], 1'b0};
			end
		end
		return c;
	endfunction

	always_ff @(posedge i_clock or posedge i_reset) begin
		if (i_reset) begin
			crc_q <= 16'h0000;
		end else if (i_clear) begin
			crc_q <= 16'h0000;
		end else if (i_byte_valid) begin
			crc_q <= crc_step(crc_q, i_byte);
		end
	end

	assign o_crc = crc_q;

	// a frame start and a data byte never share a cycle
	property p_clear_alone;
		@(posedge i_clock) disable iff (i_reset)
		!(i_clear && i_byte_valid);
	endproperty
	a_clear_alone: assert property (p_clear_alone);

endmodule

// File: src/xl320_ctrl.sv
`timescale 1ns/1ps

module xl320_ctrl #(
	parameter int CLKS_PER_BIT = 50
) (
	input  logic        i_clock,
	input  logic        i_reset,
	input  logic [15:0] i_address,
	input  logic        i_write,
	input  logic [31:0] i_writedata,
	input  logic        i_read,
	output logic [31:0] o_readdata,
	output logic        o_waitrequest,
	output logic        o_serial,
	output logic        o_busy
);

	import xl320_pkg::*;

	cmd_t        cmd;
	logic        send;
	logic        crc_clear;
	logic        crc_byte_valid;
	logic [15:0] crc;
	logic [7:0]  frame_byte;
	logic        tx_start;
	logic        tx_ready;

	xl320_cmd_regs u_cmd_regs (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_address     (i_address),
		.i_write       (i_write),
		.i_writedata   (i_writedata),
		.i_read        (i_read),
		.i_busy        (o_busy),
		.o_readdata    (o_readdata),
		.o_waitrequest (o_waitrequest),
		.o_cmd         (cmd),
		.o_send        (send)
	);

	xl320_framer u_framer (
		.i_clock          (i_clock),
		.i_reset          (i_reset),
		.i_cmd            (cmd),
		.i_send           (send),
		.i_crc            (crc),
		.i_tx_ready       (tx_ready),
		.o_crc_clear      (crc_clear),
		.o_crc_byte_valid (crc_byte_valid),
		.o_byte           (frame_byte),
		.o_tx_start       (tx_start),
		.o_busy           (o_busy)
	);

	// the crc sees the same byte bus as the serializer
	xl320_crc16 u_crc16 (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_clear      (crc_clear),
		.i_byte_valid (crc_byte_valid),
		.i_byte       (frame_byte),
		.o_crc        (crc)
	);

	xl320_uart_tx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_uart_tx (
		.i_clock  (i_clock),
		.i_reset  (i_reset),
		.i_start  (tx_start),
		.i_byte   (frame_byte),
		.o_ready  (tx_ready),
		.o_serial (o_serial)
	);

endmodule

// File: src/xl320_framer.sv
`timescale 1ns/1ps

module xl320_framer (
	input  logic                i_clock,
	input  logic                i_reset,
	input  xl320_pkg::cmd_t     i_cmd,
	input  logic                i_send,
	input  logic [15:0]         i_crc,
	input  logic                i_tx_ready,
	output logic                o_crc_clear,
	output logic                o_crc_byte_valid,
	output logic [7:0]          o_byte,
	output logic                o_tx_start,
	output logic                o_busy
);

	import xl320_pkg::*;

	frame_state_e state;
	cmd_t         cmd_q;
	logic         wide_q;
	logic [3:0]   byte_idx;
	logic [3:0]   crc_idx;
	logic [3:0]   done_idx;
	logic [7:0]   cur_byte;
	logic         is_crc;

	// one value byte gives 13 bytes on the wire, two give 14
	assign crc_idx  = wide_q ? 4'd12 : 4'd11;
	assign done_idx = crc_idx + 4'd2;

	always_comb begin
		is_crc   = 1'b0;
		cur_byte = 8'h00;
		if (byte_idx == crc_idx) begin
			cur_byte = i_crc[7:0];
			is_crc   = 1'b1;
		end else if (byte_idx > crc_idx) begin
			cur_byte = i_crc[15:8];
			is_crc   = 1'b1;
		end else begin
			case (byte_idx)
				4'd0:    cur_byte = HEADER_0;
				4'd1:    cur_byte = HEADER_1;
				4'd2:    cur_byte = HEADER_2;
				4'd3:    cur_byte = RESERVED;
				4'd4:    cur_byte = cmd_q.id;
				// length counts the value bytes only
				4'd5:    cur_byte = wide_q ? 8'd2 : 8'd1;
				4'd6:    cur_byte = 8'h00;
				4'd7:    cur_byte = cmd_q.instruction;
				4'd8:    cur_byte = cmd_q.address[7:0];
				4'd9:    cur_byte = cmd_q.address[15:8];
				4'd10:   cur_byte = cmd_q.value[7:0];
				4'd11:   cur_byte = cmd_q.value[15:8];
				default: cur_byte = 8'h00;
			endcase
		end
	end

	always_ff @(posedge i_clock or posedge i_reset) begin
		if (i_reset) begin
			state            <= FR_IDLE;
			byte_idx         <= 4'd0;
			o_crc_clear      <= 1'b0;
			o_crc_byte_valid <= 1'b0;
			o_tx_start       <= 1'b0;
		end else begin
			o_crc_clear      <= 1'b0;
			o_crc_byte_valid <= 1'b0;
			o_tx_start       <= 1'b0;
			case (state)
				FR_IDLE: begin
					// sends are only taken in idle, so one during a frame is dropped
					if (i_send) begin
						state       <= FR_SEND;
						byte_idx    <= 4'd0;
						o_crc_clear <= 1'b1;
					end
				end
				FR_SEND: begin
					if (i_tx_ready) begin
						if (byte_idx == done_idx) begin
							state <= FR_IDLE;
						end else begin
							o_tx_start       <= 1'b1;
							o_crc_byte_valid <= !is_crc;
							state            <= FR_START;
						end
					end
				end
				FR_START: begin
					// the serializer drops ready only after this cycle, so step on and wait in FR_SEND
					byte_idx <= byte_idx + 4'd1;
					state    <= FR_SEND;
				end
				default: begin
					state <= FR_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == FR_IDLE && i_send) begin
			cmd_q  <= i_cmd;
			wide_q <= is_wide_address(i_cmd.address);
		end
		if (state == FR_SEND && i_tx_ready) begin
			o_byte <= cur_byte;
		end
	end

	assign o_busy = (state != FR_IDLE);

	// the serializer must still be idle when it sees the start pulse
	property p_start_when_ready;
		@(posedge i_clock) disable iff (i_reset)
		o_tx_start |-> i_tx_ready;
	endproperty
	a_start_when_ready: assert property (p_start_when_ready);

endmodule

// File: src/xl320_pkg.sv
package xl320_pkg;

	// host register select, taken from address[15:8]
	typedef enum logic [7:0] {
		REG_MOTOR_ID      = 8'd52,
		REG_VALUE         = 8'd53,
		REG_MOTOR_ADDRESS = 8'd54,
		REG_INSTRUCTION   = 8'd55,
		REG_SEND          = 8'd56,
		REG_STATUS        = 8'd57
	} reg_sel_e;

	// protocol 2.0 instruction codes
	typedef enum logic [7:0] {
		INST_PING          = 8'h01,
		INST_READ          = 8'h02,
		INST_WRITE         = 8'h03,
		INST_REG_WRITE     = 8'h04,
		INST_ACTION        = 8'h05,
		INST_FACTORY_RESET = 8'h06,
		INST_REBOOT        = 8'h08,
		INST_SYNC_READ     = 8'h82,
		INST_SYNC_WRITE    = 8'h83,
		INST_BULK_READ     = 8'h92,
		INST_BULK_WRITE    = 8'h93
	} dxl_inst_e;

	typedef enum logic [1:0] {
		FR_IDLE,
		FR_SEND,
		FR_START
	} frame_state_e;

	typedef struct packed {
		logic [7:0]  id;
		dxl_inst_e   instruction;
		logic [15:0] address;
		logic [15:0] value;
	} cmd_t;

	localparam logic [7:0]  HEADER_0 = 8'hFF;
	localparam logic [7:0]  HEADER_1 = 8'hFF;
	localparam logic [7:0]  HEADER_2 = 8'hFD;
	localparam logic [7:0]  RESERVED = 8'h00;
	localparam logic [15:0] CRC_POLY = 16'h8005;
	localparam logic [31:0] BAD_READ = 32'hDEADBEEF;

	// control table entries that carry a two byte value
	localparam int NUM_WIDE = 11;
	localparam logic [15:0] WIDE_ADDRS [NUM_WIDE] = '{
		16'd0, 16'd6, 16'd8, 16'd15, 16'd30, 16'd32,
		16'd35, 16'd37, 16'd39, 16'd41, 16'd51
	};

	function automatic logic is_wide_address(input logic [15:0] addr);
		logic wide;
		wide = 1'b0;
		for (int i = 0; i < NUM_WIDE; i++) begin
			if (addr == WIDE_ADDRS[i]) begin
				wide = 1'b1;
			end
		end
		return wide;
	endfunction

endpackage

// File: src/xl320_uart_tx.sv
`timescale 1ns/1ps

module xl320_uart_tx #(
	parameter int CLKS_PER_BIT = 50
) (
	input  logic       i_clock,
	input  logic       i_reset,
	input  logic       i_start,
	input  logic [7:0] i_byte,
	output logic       o_ready,
	output logic       o_serial
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_e;

	tx_state_e        state;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0]       bit_idx;
	logic [7:0]       data_q;
	logic             bit_end;

	assign bit_end = (clk_cnt == LAST_CNT);

	always_ff @(posedge i_clock or posedge i_reset) begin
		if (i_reset) begin
			state    <= TX_IDLE;
			clk_cnt  <= '0;
			bit_idx  <= 3'd0;
			o_serial <= 1'b1;
		end else begin
			clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
			case (state)
				TX_IDLE: begin
					clk_cnt <= '0;
					if (i_start) begin
						state    <= TX_START;
						o_serial <= 1'b0;
					end
				end
				TX_START: begin
					if (bit_end) begin
						state    <= TX_DATA;
						bit_idx  <= 3'd0;
						o_serial <= data_q[0];
					end
				end
				TX_DATA: begin
					if (bit_end) begin
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7) begin
							state    <= TX_STOP;
							o_serial <= 1'b1;
						end else begin
							o_serial <= data_q[bit_idx + 3'd1];
						end
					end
				end
				TX_STOP: begin
					if (bit_end) begin
						state <= TX_IDLE;
					end
				end
				default: begin
					state <= TX_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == TX_IDLE && i_start) begin
			data_q <= i_byte;
		end
	end

	assign o_ready = (state == TX_IDLE);

	// line rests at mark level between bytes
	a_idle_high: assert property (@(posedge i_clock) disable iff (i_reset)
		(state == TX_IDLE) |-> o_serial);

endmodule

// File: xl320_ctrl.f
src/xl320_pkg.sv
src/xl320_crc16.sv
src/xl320_uart_tx.sv
src/xl320_cmd_regs.sv
src/xl320_framer.sv
src/xl320_ctrl.sv
dv/xl320_ctrl_tb.sv
